// File: hw/lpif_pkg.sv
// LPIF data-path widths, beat and timestamp types, and stream/protocol id mapping
package lpif_pkg;

  localparam int BEAT_W = 64; // one link-side data beat

  // LPIF stream ids
  localparam logic [7:0] MEM_CACHE_STREAM_ID = 8'h01;
  localparam logic [7:0] IO_STREAM_ID        = 8'h02;
  localparam logic [7:0] ARB_MUX_STREAM_ID   = 8'h03;

  // protocol ids carried on the link
  localparam logic [1:0] PROTID_CACHE   = 2'd0;
  localparam logic [1:0] PROTID_IO      = 2'd1;
  localparam logic [1:0] PROTID_ARB_MUX = 2'd2;

  typedef struct packed {
    logic [1:0]        protid;
    logic [BEAT_W-1:0] data;
  } beat_t;

  typedef struct packed {
    logic       tmstmp;
    logic [7:0] stream;
  } tmstmp_t;

  function automatic logic [1:0] stream_to_protid(input logic [7:0] stream);
    case (stream)
      IO_STREAM_ID:      return PROTID_IO;
      ARB_MUX_STREAM_ID: return PROTID_ARB_MUX;
      default:           return PROTID_CACHE; // unknown streams go to cache
    endcase
  endfunction

  function automatic logic [7:0] protid_to_stream(input logic [1:0] protid);
    case (protid)
      PROTID_IO:      return IO_STREAM_ID;
      PROTID_ARB_MUX: return ARB_MUX_STREAM_ID;
      default:        return MEM_CACHE_STREAM_ID; // code 3 unused
    endcase
  endfunction

endpackage

// File: hw/aib_ctl_pkg.sv
// AIB control types: link states, link-width codes, alignment and LSM info structs
package aib_ctl_pkg;

  typedef enum logic [2:0] {
    IDLE          = 3'h0,
    PHY_INIT      = 3'h1,
    CFG           = 3'h2,
    CALIB         = 3'h3,
    WAIT_CA_ALIGN = 3'h4,
    LINK_UP       = 3'h5,
    PHY_ERR       = 3'h6
  } link_state_t;

  // link-width encodings where x16 skips a code
  localparam logic [2:0] LNK_CFG_X1  = 3'b000;
  localparam logic [2:0] LNK_CFG_X2  = 3'b001;
  localparam logic [2:0] LNK_CFG_X4  = 3'b010;
  localparam logic [2:0] LNK_CFG_X8  = 3'b011;
  localparam logic [2:0] LNK_CFG_X16 = 3'b101;

  typedef struct packed {
    logic align_done;
    logic align_err;
  } ca_status_t;

  typedef struct packed {
    logic [15:0] tx_stb_intv;
    logic [15:0] rx_stb_intv;
  } ca_cfg_t;

  typedef struct packed {
    logic [3:0] state;
    logic [2:0] speedmode;
  } lsm_info_t;

endpackage

// File: hw/lpif_link_fsm.sv
// Link bring-up FSM; sequences mac-ready, adapter resets, online flags and the sticky phy error
`timescale 1ns/100ps

module lpif_link_fsm #(
  parameter int NUM_LANES = 4
) (
  input  logic                    lclk,
  input  logic                    rst_n,
  input  logic                    i_conf_done,
  input  logic [NUM_LANES-1:0]    i_ms_tx_transfer_en,
  input  logic [NUM_LANES-1:0]    i_sl_tx_transfer_en,
  input  logic [NUM_LANES-1:0]    i_wa_error,
  input  aib_ctl_pkg::ca_status_t i_ca_status,
  input  logic                    i_lp_linkerror,
  output logic                    o_cfg_load,
  output logic                    o_ns_mac_rdy,
  output logic [NUM_LANES-1:0]    o_ns_adapter_rstn,
  output logic                    o_tx_online,
  output logic                    o_rx_online,
  output logic                    o_link_up,
  output logic                    o_phy_err
);
  import aib_ctl_pkg::*;

  link_state_t state_q;
  link_state_t state_d;
  logic        lanes_en;
  logic        phy_err;

  assign lanes_en = &{i_ms_tx_transfer_en, i_sl_tx_transfer_en};
  assign phy_err  = ~lanes_en | (|i_wa_error) | i_ca_status.align_err | i_lp_linkerror;

  ////////////////////////////////////////
  // next state
  always_comb
  begin
    state_d = state_q;
    case (state_q)
      IDLE:     state_d = PHY_INIT;
      PHY_INIT:
      begin
        if (i_conf_done)
          state_d = CFG;
      end
      CFG:      state_d = CALIB; // single cycle
      CALIB:
      begin
        if (lanes_en)
          state_d = (NUM_LANES == 1) ? LINK_UP : WAIT_CA_ALIGN;
      end
      WAIT_CA_ALIGN:
      begin
        if (i_ca_status.align_done)
          state_d = LINK_UP;
      end
      LINK_UP:
      begin
        if (phy_err)
          state_d = PHY_ERR;
      end
      PHY_ERR:  state_d = PHY_ERR; // sticky until reset
      default:  state_d = IDLE;
    endcase
  end

  ////////////////////////////////////////
  // state and registered outputs
  always_ff @(posedge lclk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state_q           <= IDLE;
      o_cfg_load        <= 1'b0;
      o_ns_mac_rdy      <= 1'b0;
      o_ns_adapter_rstn <= '0;
      o_tx_online       <= 1'b0;
      o_rx_online       <= 1'b0;
      o_link_up         <= 1'b0;
      o_phy_err         <= 1'b0;
    end
    else
    begin
      state_q           <= state_d;
      o_cfg_load        <= (state_d == CFG); // one pulse in CFG
      o_ns_mac_rdy      <= (state_d inside {CFG, CALIB, WAIT_CA_ALIGN, LINK_UP, PHY_ERR});
      o_ns_adapter_rstn <= {NUM_LANES{state_d inside {CALIB, WAIT_CA_ALIGN, LINK_UP, PHY_ERR}}};
      o_tx_online       <= (state_d inside {WAIT_CA_ALIGN, LINK_UP, PHY_ERR});
      o_rx_online       <= (state_d inside {WAIT_CA_ALIGN, LINK_UP, PHY_ERR});
      o_link_up         <= (state_d == LINK_UP);
      o_phy_err         <= (state_d == PHY_ERR);
    end
  end

endmodule

// File: hw/lpif_ca_cfg.sv
// Channel-alignment configuration; latches strobe intervals at config time, holds link width
`timescale 1ns/100ps

module lpif_ca_cfg #(
  parameter int NUM_LANES = 4
) (
  input  logic                 lclk,
  input  logic                 rst_n,
  input  logic                 i_cfg_load,
  input  logic [15:0]          i_tx_stb_intv,
  input  logic [15:0]          i_rx_stb_intv,
  output aib_ctl_pkg::ca_cfg_t o_ca_cfg,
  output logic [2:0]           o_lnk_cfg
);
  import aib_ctl_pkg::*;

  // widest code the lane count supports
  localparam logic [2:0] LNK_CODE = (NUM_LANES >= 16) ? LNK_CFG_X16 :
                                    (NUM_LANES >= 8)  ? LNK_CFG_X8  :
                                    (NUM_LANES >= 4)  ? LNK_CFG_X4  :
                                    (NUM_LANES >= 2)  ? LNK_CFG_X2  : LNK_CFG_X1;

  always_ff @(posedge lclk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      o_ca_cfg  <= '0;
      o_lnk_cfg <= LNK_CFG_X1;
    end
    else
    begin
      o_lnk_cfg <= LNK_CODE;
      if (i_cfg_load)
        o_ca_cfg <= '{tx_stb_intv: i_tx_stb_intv, rx_stb_intv: i_rx_stb_intv};
    end
  end

endmodule

// File: hw/lpif_dstrm_serializer.sv
// Downstream serializer; splits each accepted LPIF word into NUM_BEATS link beats
`timescale 1ns/100ps

module lpif_dstrm_serializer #(
  parameter int NUM_BEATS = 4
) (
  input  logic                                lclk,
  input  logic                                rst_n,
  input  logic                                i_lp_irdy,
  input  logic [NUM_BEATS*lpif_pkg::BEAT_W-1:0] i_lp_data,
  input  logic [7:0]                          i_lp_stream,
  input  logic                                i_lsm_active,
  output logic                                o_pl_trdy,
  output logic                                o_dstrm_valid,
  output lpif_pkg::beat_t                     o_dstrm
);
  import lpif_pkg::*;

  localparam int CNT_W = (NUM_BEATS > 1) ? $clog2(NUM_BEATS) : 1;

  logic [NUM_BEATS*BEAT_W-1:0] word_q;  // held word for beats 1..N-1
  logic [CNT_W-1:0]            beat_q;  // next beat to send
  logic                        busy_q;
  logic                        accept;
  logic                        last_beat;
  logic                        valid_d;

  assign accept    = i_lp_irdy & o_pl_trdy;
  assign last_beat = (beat_q == CNT_W'(NUM_BEATS - 1));
  assign valid_d   = accept | busy_q;

  ////////////////////////////////////////
  // beat sequencing
  always_ff @(posedge lclk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      busy_q        <= 1'b0;
      beat_q        <= '0;
      o_dstrm_valid <= 1'b0;
      o_pl_trdy     <= 1'b0;
    end
    else
    begin
      o_dstrm_valid <= valid_d;
      o_pl_trdy     <= i_lsm_active & ~valid_d; // stays low through the last beat
      if (accept)
      begin
        busy_q <= (NUM_BEATS > 1);
        beat_q <= CNT_W'(1);
      end
      else if (busy_q)
      begin
        busy_q <= ~last_beat;
        beat_q <= beat_q + 1'b1;
      end
    end
  end

  // beat 0 goes straight from the input word
  always_ff @(posedge lclk)
  begin
    if (accept)
    begin
      word_q         <= i_lp_data;
      o_dstrm.protid <= stream_to_protid(i_lp_stream);
      o_dstrm.data   <= i_lp_data[BEAT_W-1:0];
    end
    else if (busy_q)
      o_dstrm.data <= word_q[beat_q*BEAT_W +: BEAT_W];
  end

endmodule

// File: hw/lpif_ustrm_deserializer.sv
// Upstream deserializer; collects NUM_BEATS link beats into one LPIF word with a valid pulse
`timescale 1ns/100ps

module lpif_ustrm_deserializer #(
  parameter int NUM_BEATS = 4
) (
  input  logic                                lclk,
  input  logic                                rst_n,
  input  logic                                i_ustrm_valid,
  input  lpif_pkg::beat_t                     i_ustrm,
  output logic                                o_pl_valid,
  output logic [NUM_BEATS*lpif_pkg::BEAT_W-1:0] o_pl_data,
  output logic [7:0]                          o_pl_stream
);
  import lpif_pkg::*;

  localparam int CNT_W = (NUM_BEATS > 1) ? $clog2(NUM_BEATS) : 1;

  logic [NUM_BEATS*BEAT_W-1:0] asm_q;
  logic [NUM_BEATS*BEAT_W-1:0] word_d;
  logic [CNT_W-1:0]            beat_q; // slice for the next valid beat
  logic                        last_beat;

  assign last_beat = (beat_q == CNT_W'(NUM_BEATS - 1));

  // current beat merged into the partial word
  always_comb
  begin
    word_d = asm_q;
    word_d[beat_q*BEAT_W +: BEAT_W] = i_ustrm.data;
  end

  always_ff @(posedge lclk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      beat_q     <= '0;
      o_pl_valid <= 1'b0;
    end
    else
    begin
      o_pl_valid <= i_ustrm_valid & last_beat;
      if (i_ustrm_valid)
        beat_q <= last_beat ? '0 : beat_q + 1'b1;
    end
  end

  always_ff @(posedge lclk)
  begin
    if (i_ustrm_valid)
      asm_q <= word_d;
    if (i_ustrm_valid && last_beat)
    begin
      o_pl_data   <= word_d;
      o_pl_stream <= protid_to_stream(i_ustrm.protid); // from the last beat
    end
  end

endmodule

// File: hw/lpif_delay_line.sv
// Fixed-depth register pipeline; payload type set per instance
`timescale 1ns/100ps

module lpif_delay_line #(
  parameter type payload_t = logic,
  parameter int  DEPTH     = 1
) (
  input  logic     lclk,
  input  logic     rst_n,
  input  payload_t i_d,
  output payload_t o_q
);

  payload_t stage_q [DEPTH]; // stage 0 is closest to the input

  always_ff @(posedge lclk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      for (int i = 0; i < DEPTH; i++)
        stage_q[i] <= '0;
    end
    else
    begin
      stage_q[0] <= i_d;
      for (int i = 1; i < DEPTH; i++)
        stage_q[i] <= stage_q[i-1];
    end
  end

  assign o_q = stage_q[DEPTH-1];

endmodule

// File: hw/lpif_ctl_top.sv
// LPIF adapter control top; ties the link FSM, config, data paths and delay lines together
`timescale 1ns/100ps

module lpif_ctl_top #(
  parameter int NUM_BEATS    = 4,
  parameter int NUM_LANES    = 4,
  parameter int PTM_RX_DELAY = 4
) (
  input  logic                                lclk,
  input  logic                                rst_n,
  // downstream
  input  logic                                i_lp_irdy,
  input  logic [NUM_BEATS*lpif_pkg::BEAT_W-1:0] i_lp_data,
  input  logic [7:0]                          i_lp_stream,
  output logic                                o_pl_trdy,
  output logic                                o_dstrm_valid,
  output lpif_pkg::beat_t                     o_dstrm,
  // upstream
  input  logic                                i_ustrm_valid,
  input  lpif_pkg::beat_t                     i_ustrm,
  output logic                                o_pl_valid,
  output logic [NUM_BEATS*lpif_pkg::BEAT_W-1:0] o_pl_data,
  output logic [7:0]                          o_pl_stream,
  // timestamp and lsm
  input  lpif_pkg::tmstmp_t                   i_lp_tmstmp,
  output lpif_pkg::tmstmp_t                   o_pl_tmstmp,
  input  aib_ctl_pkg::lsm_info_t              i_lsm,
  input  logic                                i_lsm_active,
  output aib_ctl_pkg::lsm_info_t              o_lsm,
  // bring-up and error
  input  logic                                i_conf_done,
  input  logic [NUM_LANES-1:0]                i_ms_tx_transfer_en,
  input  logic [NUM_LANES-1:0]                i_sl_tx_transfer_en,
  input  logic [NUM_LANES-1:0]                i_wa_error,
  input  aib_ctl_pkg::ca_status_t             i_ca_status,
  input  logic                                i_lp_linkerror,
  output logic                                o_ns_mac_rdy,
  output logic [NUM_LANES-1:0]                o_ns_adapter_rstn,
  output logic                                o_tx_online,
  output logic                                o_rx_online,
  output logic                                o_link_up,
  output logic                                o_phy_err,
  // channel alignment config
  input  logic [15:0]                         i_tx_stb_intv,
  input  logic [15:0]                         i_rx_stb_intv,
  output aib_ctl_pkg::ca_cfg_t                o_ca_cfg,
  output logic [2:0]                          o_lnk_cfg
);
  import lpif_pkg::*;
  import aib_ctl_pkg::*;

  logic cfg_load; // fsm to config block

  ////////////////////////////////////////
  // link control
  lpif_link_fsm #(.NUM_LANES(NUM_LANES)) u_link_fsm (
    .lclk, .rst_n, .i_conf_done, .i_ms_tx_transfer_en, .i_sl_tx_transfer_en,
    .i_wa_error, .i_ca_status, .i_lp_linkerror,
    .o_cfg_load(cfg_load),
    .o_ns_mac_rdy, .o_ns_adapter_rstn, .o_tx_online, .o_rx_online,
    .o_link_up, .o_phy_err
  );

  lpif_ca_cfg #(.NUM_LANES(NUM_LANES)) u_ca_cfg (
    .lclk, .rst_n, .i_cfg_load(cfg_load), .i_tx_stb_intv, .i_rx_stb_intv,
    .o_ca_cfg, .o_lnk_cfg
  );

  ////////////////////////////////////////
  // data paths
  lpif_dstrm_serializer #(.NUM_BEATS(NUM_BEATS)) u_dstrm_ser (
    .lclk, .rst_n, .i_lp_irdy, .i_lp_data, .i_lp_stream, .i_lsm_active,
    .o_pl_trdy, .o_dstrm_valid, .o_dstrm
  );

  lpif_ustrm_deserializer #(.NUM_BEATS(NUM_BEATS)) u_ustrm_deser (
    .lclk, .rst_n, .i_ustrm_valid, .i_ustrm, .o_pl_valid, .o_pl_data, .o_pl_stream
  );

  // fixed PTM delay and one-cycle lsm register
  lpif_delay_line #(.payload_t(tmstmp_t), .DEPTH(PTM_RX_DELAY)) u_tmstmp_dly (
    .lclk, .rst_n, .i_d(i_lp_tmstmp), .o_q(o_pl_tmstmp)
  );

  lpif_delay_line #(.payload_t(lsm_info_t), .DEPTH(1)) u_lsm_dly (
    .lclk, .rst_n, .i_d(i_lsm), .o_q(o_lsm)
  );

endmodule

// File: verification/lpif_ctl_sva.sv
// Concurrent assertions bound into the LPIF control top; trdy/beat exclusion, valid pulse, sticky error
`timescale 1ns/100ps

module lpif_ctl_sva (
  input logic lclk,
  input logic rst_n,
  input logic o_pl_trdy,
  input logic o_dstrm_valid,
  input logic o_pl_valid,
  input logic o_phy_err
);

  // no new word offered while beats go out
  a_trdy_vs_beat: assert property (@(posedge lclk) disable iff (!rst_n)
    !(o_pl_trdy && o_dstrm_valid))
    else $error("o_pl_trdy high during a downstream beat");

  a_pl_valid_pulse: assert property (@(posedge lclk) disable iff (!rst_n)
    o_pl_valid |=> !o_pl_valid)
    else $error("o_pl_valid longer than one cycle");

  a_phy_err_sticky: assert property (@(posedge lclk) disable iff (!rst_n)
    o_phy_err |=> o_phy_err) // only reset clears it
    else $error("o_phy_err fell before reset");

endmodule

bind lpif_ctl_top lpif_ctl_sva u_ctl_sva (.*);

// File: verification/lpif_ctl_tb.sv
// Testbench for the LPIF control top; runs bring-up, both data paths, the delay lines and a phy error
`timescale 1ns/100ps

module lpif_ctl_tb;
  import lpif_pkg::*;
  import aib_ctl_pkg::*;

  localparam int  NUM_BEATS      = 4;
  localparam int  NUM_LANES      = 4;
  localparam int  PTM_RX_DELAY   = 4;
  localparam int  WORD_W         = NUM_BEATS * BEAT_W;
  localparam int  NUM_WORDS      = 40;
  localparam time CLK_PERIOD     = 10;
  localparam int  TIMEOUT_CYCLES = NUM_WORDS * (NUM_BEATS + 4) * 2 + 100;

  logic                 lclk;
  logic                 rst_n;
  logic                 i_lp_irdy;
  logic [WORD_W-1:0]    i_lp_data;
  logic [7:0]           i_lp_stream;
  logic                 o_pl_trdy;
  logic                 o_dstrm_valid;
  beat_t                o_dstrm;
  logic                 i_ustrm_valid;
  beat_t                i_ustrm;
  logic                 o_pl_valid;
  logic [WORD_W-1:0]    o_pl_data;
  logic [7:0]           o_pl_stream;
  tmstmp_t              i_lp_tmstmp;
  tmstmp_t              o_pl_tmstmp;
  lsm_info_t            i_lsm;
  logic                 i_lsm_active;
  lsm_info_t            o_lsm;
  logic                 i_conf_done;
  logic [NUM_LANES-1:0] i_ms_tx_transfer_en;
  logic [NUM_LANES-1:0] i_sl_tx_transfer_en;
  logic [NUM_LANES-1:0] i_wa_error;
  ca_status_t           i_ca_status;
  logic                 i_lp_linkerror;
  logic                 o_ns_mac_rdy;
  logic [NUM_LANES-1:0] o_ns_adapter_rstn;
  logic                 o_tx_online;
  logic                 o_rx_online;
  logic                 o_link_up;
  logic                 o_phy_err;
  logic [15:0]          i_tx_stb_intv;
  logic [15:0]          i_rx_stb_intv;
  ca_cfg_t              o_ca_cfg;
  logic [2:0]           o_lnk_cfg;

  logic [15:0]       lfsr_q = 16'd76;
  beat_t             exp_beats[$];
  logic [WORD_W-1:0] exp_words[$];
  logic [7:0]        exp_streams[$];
  tmstmp_t           tm_hist[$];    // newest first
  lsm_info_t         lsm_hist[$];
  logic              prev_pl_valid = 1'b0;
  logic              phy_err_seen = 1'b0;

  lpif_ctl_top u_lpif_ctl_top (.*);

  ////////////////////////////////////////
  // helpers
  // x^16 + x^14 + x^13 + x^11 + 1 stepped once per bit
  function automatic logic [63:0] lfsr_bits(input int n);
    logic [63:0] r;
    r = '0;
    for (int i = 0; i < n; i++)
    begin
      lfsr_q = {lfsr_q[14:0], lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10]};
      r = {r[62:0], lfsr_q[0]};
    end
    return r;
  endfunction

  // expected downstream beat k of a word
  function automatic beat_t ref_beat(input logic [WORD_W-1:0] word, input logic [7:0] stream,
                                     input int k);
    beat_t b;
    case (stream)
      8'd2:    b.protid = 2'd1; // io
      8'd3:    b.protid = 2'd2; // arb/mux
      default: b.protid = 2'd0; // mem-cache and any unknown id
    endcase
    b.data = word[k*BEAT_W +: BEAT_W];
    return b;
  endfunction

  function automatic logic [7:0] ref_stream(input logic [1:0] protid);
    case (protid)
      2'd1:    return 8'd2;
      2'd2:    return 8'd3;
      default: return 8'd1; // code 3 lands on mem-cache
    endcase
  endfunction

  task automatic fail_run(input string why);
    $display("Error at %0t ns: %s", $time, why);
    $display("STATUS: FAIL");
    $fatal(1, "run stopped");
  endtask

  task automatic compare_value(input string name, input logic [WORD_W-1:0] got,
                               input logic [WORD_W-1:0] exp);
    if (got !== exp)
    begin
      $display("Mismatch at %0t ns: %s got 0x%0h expected 0x%0h", $time, name, got, exp);
      fail_run("value mismatch");
    end
  endtask

  ////////////////////////////////////////
  // clock and watchdog
  initial
  begin
    lclk = 1'b0;
    forever #(CLK_PERIOD / 2) lclk = ~lclk;
  end

  initial
  begin
    #(TIMEOUT_CYCLES * CLK_PERIOD);
    fail_run("timeout, the DUT stopped responding");
  end

  ////////////////////////////////////////
  // compare process samples on the falling edge
  always @(negedge lclk)
  begin
    if (rst_n)
    begin
      if (o_pl_trdy && o_dstrm_valid)
        fail_run("o_pl_trdy high while a downstream beat is valid");
      if (o_dstrm_valid)
      begin
        if (exp_beats.size() == 0)
          fail_run("downstream beat with no accepted word behind it");
        compare_value("o_dstrm", o_dstrm, exp_beats.pop_front());
      end
      if (o_pl_valid)
      begin
        if (prev_pl_valid)
          fail_run("o_pl_valid high for more than one cycle");
        if (exp_words.size() == 0)
          fail_run("upstream word with no complete set of beats");
        compare_value("o_pl_data", o_pl_data, exp_words.pop_front());
        compare_value("o_pl_stream", o_pl_stream, exp_streams.pop_front());
      end
      prev_pl_valid = o_pl_valid;
      if (phy_err_seen && !o_phy_err)
        fail_run("o_phy_err fell without a reset");
      phy_err_seen = phy_err_seen | o_phy_err;
      tm_hist.push_front(i_lp_tmstmp);
      lsm_hist.push_front(i_lsm);
      if (tm_hist.size() > PTM_RX_DELAY)
      begin
        compare_value("o_pl_tmstmp", o_pl_tmstmp, tm_hist[PTM_RX_DELAY]);
        void'(tm_hist.pop_back());
      end
      if (lsm_hist.size() > 1)
      begin
        compare_value("o_lsm", o_lsm, lsm_hist[1]);
        void'(lsm_hist.pop_back());
      end
    end
  end

  // timestamp and lsm inputs change every cycle
  initial
  begin
    @(posedge rst_n);
    forever
    begin
      @(posedge lclk);
      #1;
      i_lp_tmstmp = tmstmp_t'(lfsr_bits(9));
      i_lsm       = lsm_info_t'(lfsr_bits(7));
    end
  end

  ////////////////////////////////////////
  // test sequences
  task automatic bring_up();
    logic [15:0] tx_intv;
    logic [15:0] rx_intv;
    tx_intv = 16'(lfsr_bits(16));
    rx_intv = 16'(lfsr_bits(16));
    @(posedge lclk);
    #1;
    i_tx_stb_intv = tx_intv;
    i_rx_stb_intv = rx_intv;
    i_conf_done   = 1'b1;
    do @(negedge lclk); while (!o_ns_mac_rdy);
    do @(negedge lclk); while (o_ns_adapter_rstn == '0);
    compare_value("o_ns_adapter_rstn", o_ns_adapter_rstn, {NUM_LANES{1'b1}});
    @(posedge lclk);
    #1;
    i_ms_tx_transfer_en = '1;
    i_sl_tx_transfer_en = '1;
    do @(negedge lclk); while (!o_tx_online);
    compare_value("o_rx_online", o_rx_online, 1'b1);
    @(posedge lclk);
    #1;
    i_ca_status.align_done = 1'b1;
    do @(negedge lclk); while (!o_link_up);
    @(posedge lclk);
    #1;
    i_tx_stb_intv = ~tx_intv; // config keeps the latched values
    i_rx_stb_intv = ~rx_intv;
    i_lsm_active  = 1'b1;
    repeat (2) @(negedge lclk);
    compare_value("o_ca_cfg", o_ca_cfg, {tx_intv, rx_intv});
    compare_value("o_lnk_cfg", o_lnk_cfg, LNK_CFG_X4);
  endtask

  task automatic run_downstream();
    logic [WORD_W-1:0] word;
    logic [7:0]        stream;
    for (int w = 0; w < NUM_WORDS; w++)
    begin
      for (int k = 0; k < NUM_BEATS; k++)
        word[k*BEAT_W +: BEAT_W] = lfsr_bits(BEAT_W);
      stream = 8'(lfsr_bits(3)); // ids 0..7 with some unknown
      @(posedge lclk);
      #1;
      i_lp_irdy   = 1'b1;
      i_lp_data   = word;
      i_lp_stream = stream;
      do @(negedge lclk); while (!o_pl_trdy);
      @(posedge lclk); // word taken on this edge
      for (int k = 0; k < NUM_BEATS; k++)
        exp_beats.push_back(ref_beat(word, stream, k));
      #1;
      i_lp_irdy = 1'b0;
    end
  endtask

  task automatic run_upstream();
    logic [WORD_W-1:0] word;
    beat_t             beat;
    int                slice;
    int                sent;
    word  = '0;
    slice = 0;
    sent  = 0;
    while (sent < NUM_WORDS)
    begin
      @(posedge lclk);
      #1;
      beat.protid   = 2'(lfsr_bits(2));
      beat.data     = lfsr_bits(BEAT_W);
      i_ustrm       = beat;
      i_ustrm_valid = (lfsr_bits(2) != 0); // about one gap in four
      if (i_ustrm_valid)
      begin
        word[slice*BEAT_W +: BEAT_W] = beat.data;
        if (slice == NUM_BEATS - 1)
        begin
          exp_words.push_back(word);
          exp_streams.push_back(ref_stream(beat.protid));
          slice = 0;
          sent++;
        end
        else
          slice++;
      end
    end
    @(posedge lclk);
    #1;
    i_ustrm_valid = 1'b0;
  endtask

  task automatic inject_phy_err();
    @(posedge lclk);
    #1;
    i_ms_tx_transfer_en[1] = 1'b0;
    do @(negedge lclk); while (!o_phy_err);
    compare_value("o_link_up", o_link_up, 1'b0);
    @(posedge lclk);
    #1;
    i_ms_tx_transfer_en[1] = 1'b1;
    repeat (4) @(negedge lclk);
    compare_value("o_phy_err", o_phy_err, 1'b1);
    compare_value("o_link_up", o_link_up, 1'b0);
  endtask

  initial
  begin
    rst_n               = 1'b0;
    i_lp_irdy           = 1'b0;
    i_lp_data           = '0;
    i_lp_stream         = '0;
    i_ustrm_valid       = 1'b0;
    i_ustrm             = '0;
    i_lp_tmstmp         = '0;
    i_lsm               = '0;
    i_lsm_active        = 1'b0;
    i_conf_done         = 1'b0;
    i_ms_tx_transfer_en = '0;
    i_sl_tx_transfer_en = '0;
    i_wa_error          = '0;
    i_ca_status         = '0;
    i_lp_linkerror      = 1'b0;
    i_tx_stb_intv       = '0;
    i_rx_stb_intv       = '0;
    repeat (3) @(posedge lclk);
    @(negedge lclk);
    compare_value("control outputs in reset", {o_pl_trdy, o_dstrm_valid, o_pl_valid,
                  o_ns_mac_rdy, o_ns_adapter_rstn, o_tx_online, o_rx_online, o_link_up,
                  o_phy_err}, '0);
    @(posedge lclk);
    #1;
    rst_n = 1'b1;
    bring_up();
    fork
      run_downstream();
      run_upstream();
    join
    while (exp_beats.size() != 0 || exp_words.size() != 0)
      @(negedge lclk);
    inject_phy_err();
    $display("STATUS: PASS");
    $finish;
  end

endmodule

// File: sources.f
hw/lpif_pkg.sv
hw/aib_ctl_pkg.sv
hw/lpif_link_fsm.sv
hw/lpif_ca_cfg.sv
hw/lpif_dstrm_serializer.sv
hw/lpif_ustrm_deserializer.sv
hw/lpif_delay_line.sv
hw/lpif_ctl_top.sv
verification/lpif_ctl_sva.sv
verification/lpif_ctl_tb.sv

// File: Bender.yml
package:
  name: lpif_ctl

sources:
  # packages first, then the blocks and the top level
  - files:
      - hw/lpif_pkg.sv
      - hw/aib_ctl_pkg.sv
      - hw/lpif_link_fsm.sv
      - hw/lpif_ca_cfg.sv
      - hw/lpif_dstrm_serializer.sv
      - hw/lpif_ustrm_deserializer.sv
      - hw/lpif_delay_line.sv
      - hw/lpif_ctl_top.sv
  - target: test
    files:
      - verification/lpif_ctl_sva.sv
      - verification/lpif_ctl_tb.sv
